//--- agc_config.svh
// AGC address unit configuration
// Word, address and bank field widths plus the octal region
// boundaries used by the read-side address translation
`ifndef AGC_CONFIG_SVH
`define AGC_CONFIG_SVH

// Datapath word, one's-complement 15 bits
`define AGC_WORD_W          15

// Software address as seen by the instruction stream
`define AGC_SOFT_ADDR_W     12

// Physical memory address widths
`define AGC_ROM_ADDR_W      14
`define AGC_RAM_ADDR_W      11

// One bank field (EB or FB)
`define AGC_BANK_W          3

// ROM region boundaries, software view
`define AGC_ROM_REGION      12'o2000
`define AGC_FIXED_ROM_BASE  12'o4000
`define AGC_ROM_BANK_SIZE   14'o2000

// RAM region boundaries
`define AGC_BANKED_RAM_BASE 12'o1400
`define AGC_RAM_BANK_SIZE   11'o0400
// Used instead of the bank table when EB[2] is set
`define AGC_EB_HI_OFFSET    11'o2000

`endif

//--- agc_pkg.sv
// AGC address unit shared types
// Register-select opcode, region tag, bank bits and the
// translation request and response records
`include "agc_config.svh"

package agc_pkg;

  // Bank register select on the Wishbone address
  typedef enum logic [1:0] {
    EB_SEL = 2'd0,
    FB_SEL = 2'd1,
    BB_SEL = 2'd2
  } bank_sel_e;

  // Which memory a translated address lands in
  typedef enum logic {
    REGION_RAM = 1'b0,
    REGION_ROM = 1'b1
  } region_e;

  typedef struct packed {
    logic [`AGC_BANK_W-1:0] eb;
    logic [`AGC_BANK_W-1:0] fb;
  } bank_bits_t;

  typedef struct packed {
    logic                        valid;
    logic [`AGC_SOFT_ADDR_W-1:0] addr;
  } xlate_req_t;

  typedef struct packed {
    logic                       valid;
    region_e                    region;
    logic [`AGC_ROM_ADDR_W-1:0] rom_addr;
    logic [`AGC_RAM_ADDR_W-1:0] ram_addr;
  } xlate_rsp_t;

endpackage

//--- bank_regs.sv
// Bank register, Wishbone classic slave
// Holds the erasable (EB) and fixed (FB) bank fields. BB is the
// combined view of both fields in one word. Single-cycle ack,
// never stalls.
`timescale 1ns/100ps
`include "agc_config.svh"

module bank_regs import agc_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_l,
  input  logic                   wb_cyc,
  input  logic                   wb_stb,
  input  logic                   wb_we,
  input  bank_sel_e              wb_adr,
  input  logic [`AGC_WORD_W-1:0] wb_dat_w,
  output logic [`AGC_WORD_W-1:0] wb_dat_r,
  output logic                   wb_ack,
  output bank_bits_t             banks
);

  // Field positions within the data word
  localparam int EB_LSB = 9;
  localparam int FB_LSB = EB_LSB + `AGC_BANK_W;

  logic                   bus_req;
  logic [`AGC_WORD_W-1:0] rd_word;
  bank_bits_t             bank_q;

  // New request only while ack is low, so each strobe gets one ack
  assign bus_req = wb_cyc & wb_stb & ~wb_ack;

  always_ff @(posedge clk, negedge rst_l) begin
    if (!rst_l) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= bus_req;
    end
  end

  // Partial-field writes, commit on the ack edge
  always_ff @(posedge clk, negedge rst_l) begin
    if (!rst_l) begin
      bank_q <= '0;
    end else if (bus_req && wb_we) begin
      case (wb_adr)
        EB_SEL: bank_q.eb <= wb_dat_w[EB_LSB +: `AGC_BANK_W];
        FB_SEL: bank_q.fb <= wb_dat_w[FB_LSB +: `AGC_BANK_W];
        BB_SEL: {bank_q.fb, bank_q.eb} <= wb_dat_w[EB_LSB +: 2*`AGC_BANK_W];
        default: begin
          // Unmapped select, write ignored
        end
      endcase
    end
  end

  // Read-back view, unused bits read zero
  always_comb begin
    rd_word = '0;
    case (wb_adr)
      EB_SEL: rd_word[EB_LSB +: `AGC_BANK_W] = bank_q.eb;
      FB_SEL: rd_word[FB_LSB +: `AGC_BANK_W] = bank_q.fb;
      BB_SEL: rd_word[EB_LSB +: 2*`AGC_BANK_W] = {bank_q.fb, bank_q.eb};
      default: rd_word = '0;
    endcase
  end

  // Read data lands together with ack
  always_ff @(posedge clk) begin
    if (bus_req) begin
      wb_dat_r <= rd_word;
    end
  end

  // Taps for the translators
  assign banks = bank_q;

endmodule

//--- rom_translate.sv
// ROM address translator
// Maps a software address onto physical ROM. Addresses from
// octal 4000 up are fixed ROM, lower ROM addresses go through FB.
`timescale 1ns/100ps
`include "agc_config.svh"

module rom_translate (
  input  logic [`AGC_SOFT_ADDR_W-1:0] addr,
  input  logic [`AGC_BANK_W-1:0]      fb,
  output logic [`AGC_ROM_ADDR_W-1:0]  rom_addr
);

  logic                        is_fixed;
  logic [`AGC_SOFT_ADDR_W-1:0] fixed_addr;
  logic [`AGC_ROM_ADDR_W-1:0]  bank_off;
  logic [`AGC_ROM_ADDR_W-1:0]  banked_addr;

  always_comb begin
    is_fixed = addr >= `AGC_FIXED_ROM_BASE;

    // Fixed ROM sits at the bottom of physical ROM
    fixed_addr = addr - `AGC_FIXED_ROM_BASE;

    // Bank offset from a table, no multiplier in the path
    case (fb)
      3'd0: bank_off = '0;
      3'd1: bank_off = `AGC_ROM_BANK_SIZE;
      3'd2: bank_off = `AGC_ROM_BANK_SIZE * 14'd2;
      3'd3: bank_off = `AGC_ROM_BANK_SIZE * 14'd3;
      3'd4: bank_off = `AGC_ROM_BANK_SIZE * 14'd4;
      3'd5: bank_off = `AGC_ROM_BANK_SIZE * 14'd5;
      3'd6: bank_off = `AGC_ROM_BANK_SIZE * 14'd6;
      3'd7: bank_off = `AGC_ROM_BANK_SIZE * 14'd7;
    endcase

    // Banked window starts one bank above the fixed area
    banked_addr = {{(`AGC_ROM_ADDR_W-`AGC_SOFT_ADDR_W){1'b0}}, addr}
                  + `AGC_ROM_BANK_SIZE + bank_off;

    rom_addr = is_fixed ? {{(`AGC_ROM_ADDR_W-`AGC_SOFT_ADDR_W){1'b0}}, fixed_addr}
                        : banked_addr;
  end

endmodule

//--- ram_translate.sv
// RAM address translator
// Maps a software address onto physical RAM. Below octal 1400 is
// fixed erasable, the window above it is selected by EB.
`timescale 1ns/100ps
`include "agc_config.svh"

module ram_translate (
  input  logic [`AGC_SOFT_ADDR_W-1:0] addr,
  input  logic [`AGC_BANK_W-1:0]      eb,
  output logic [`AGC_RAM_ADDR_W-1:0]  ram_addr
);

  logic                       is_fixed;
  logic [`AGC_RAM_ADDR_W-1:0] low_addr;
  logic [`AGC_RAM_ADDR_W-1:0] tbl_off;
  logic [`AGC_RAM_ADDR_W-1:0] bank_off;
  logic [`AGC_RAM_ADDR_W-1:0] banked_addr;

  always_comb begin
    is_fixed = addr < `AGC_BANKED_RAM_BASE;

    // Only the low bits reach physical RAM
    low_addr = addr[`AGC_RAM_ADDR_W-1:0];

    // Bank offset from the low two EB bits
    case (eb[1:0])
      2'd0: tbl_off = '0;
      2'd1: tbl_off = `AGC_RAM_BANK_SIZE;
      2'd2: tbl_off = `AGC_RAM_BANK_SIZE * 11'd2;
      2'd3: tbl_off = `AGC_RAM_BANK_SIZE * 11'd3;
    endcase

    // Top EB bit overrides the table
    bank_off = eb[`AGC_BANK_W-1] ? `AGC_EB_HI_OFFSET : tbl_off;

    banked_addr = low_addr + bank_off;

    ram_addr = is_fixed ? low_addr : banked_addr;
  end

endmodule

//--- xlate_combine.sv
// Translation response stage
// Tags ROM or RAM by address region, parks the unused side at its
// lowest valid address and registers the response. One request
// per cycle, no back-pressure, 1-cycle latency.
`timescale 1ns/100ps
`include "agc_config.svh"

module xlate_combine import agc_pkg::*; (
  input  logic                       clk,
  input  logic                       rst_l,
  input  xlate_req_t                 req,
  input  logic [`AGC_ROM_ADDR_W-1:0] rom_addr,
  input  logic [`AGC_RAM_ADDR_W-1:0] ram_addr,
  output xlate_rsp_t                 rsp
);

  region_e                    region;
  logic [`AGC_ROM_ADDR_W-1:0] rom_sel;
  logic [`AGC_RAM_ADDR_W-1:0] ram_sel;

  logic                       valid_q;
  region_e                    region_q;
  logic [`AGC_ROM_ADDR_W-1:0] rom_q;
  logic [`AGC_RAM_ADDR_W-1:0] ram_q;

  always_comb begin
    region = (req.addr >= `AGC_ROM_REGION) ? REGION_ROM : REGION_RAM;

    // Inactive side shows its lowest valid address
    rom_sel = (region == REGION_ROM) ? rom_addr
            : {{(`AGC_ROM_ADDR_W-`AGC_SOFT_ADDR_W){1'b0}}, `AGC_ROM_REGION};
    ram_sel = (region == REGION_ROM) ? '0 : ram_addr;
  end

  always_ff @(posedge clk, negedge rst_l) begin
    if (!rst_l) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= req.valid;
    end
  end

  // Payload only moves with a valid request
  always_ff @(posedge clk) begin
    if (req.valid) begin
      region_q <= region;
      rom_q    <= rom_sel;
      ram_q    <= ram_sel;
    end
  end

  always_comb begin
    rsp = '{valid: valid_q, region: region_q, rom_addr: rom_q, ram_addr: ram_q};
  end

endmodule

//--- agc_addr_unit.sv
// AGC address unit, top level
// Bank register on Wishbone feeding the ROM and RAM translators,
// whose results are merged and registered by the response stage
`timescale 1ns/100ps
`include "agc_config.svh"

module agc_addr_unit import agc_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_l,
  input  logic                   wb_cyc,
  input  logic                   wb_stb,
  input  logic                   wb_we,
  input  bank_sel_e              wb_adr,
  input  logic [`AGC_WORD_W-1:0] wb_dat_w,
  output logic [`AGC_WORD_W-1:0] wb_dat_r,
  output logic                   wb_ack,
  input  xlate_req_t             xlate_req,
  output xlate_rsp_t             xlate_rsp
);

  bank_bits_t                 banks;
  logic [`AGC_ROM_ADDR_W-1:0] rom_addr;
  logic [`AGC_RAM_ADDR_W-1:0] ram_addr;

  bank_regs u_bank_regs (
    .clk      (clk),
    .rst_l    (rst_l),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .banks    (banks)
  );

  // FB selects the ROM window
  rom_translate u_rom_translate (
    .addr     (xlate_req.addr),
    .fb       (banks.fb),
    .rom_addr (rom_addr)
  );

  // EB selects the RAM window
  ram_translate u_ram_translate (
    .addr     (xlate_req.addr),
    .eb       (banks.eb),
    .ram_addr (ram_addr)
  );

  xlate_combine u_xlate_combine (
    .clk      (clk),
    .rst_l    (rst_l),
    .req      (xlate_req),
    .rom_addr (rom_addr),
    .ram_addr (ram_addr),
    .rsp      (xlate_rsp)
  );

endmodule

//--- agc_addr_unit_assert.sv
// AGC address unit checker, bound to the top level
// Wishbone ack handshake, reset state, translation latency and the
// ROM and RAM mapping rules against the previous cycle's request
`timescale 1ns/100ps
`include "agc_config.svh"

module agc_addr_unit_assert import agc_pkg::*; (
  input logic                   clk,
  input logic                   rst_l,
  input logic                   wb_cyc,
  input logic                   wb_stb,
  input logic                   wb_ack,
  input xlate_req_t             xlate_req,
  input xlate_rsp_t             xlate_rsp,
  input bank_bits_t             banks
);

  // Failures seen so far, read by the testbench at the end
  int unsigned fail_cnt = 0;

  // Fixed ROM drops the base, banked ROM sits one bank up plus FB banks
  function automatic logic [`AGC_ROM_ADDR_W-1:0] exp_rom(
    input logic [`AGC_SOFT_ADDR_W-1:0] a,
    input logic [`AGC_BANK_W-1:0]      fb
  );
    logic [`AGC_ROM_ADDR_W-1:0] a_ext;
    logic [`AGC_ROM_ADDR_W-1:0] fb_ext;
    a_ext  = a;
    fb_ext = fb;
    if (a >= `AGC_FIXED_ROM_BASE) begin
      exp_rom = a_ext - `AGC_FIXED_ROM_BASE;
    end else begin
      exp_rom = a_ext + `AGC_ROM_BANK_SIZE + fb_ext * `AGC_ROM_BANK_SIZE;
    end
  endfunction

  // Low 11 bits, plus the EB window above the fixed erasable area
  function automatic logic [`AGC_RAM_ADDR_W-1:0] exp_ram(
    input logic [`AGC_SOFT_ADDR_W-1:0] a,
    input logic [`AGC_BANK_W-1:0]      eb
  );
    logic [`AGC_RAM_ADDR_W-1:0] eb_lo;
    eb_lo = eb[1:0];
    if (a < `AGC_BANKED_RAM_BASE) begin
      exp_ram = a[`AGC_RAM_ADDR_W-1:0];
    end else if (eb[`AGC_BANK_W-1]) begin
      exp_ram = a[`AGC_RAM_ADDR_W-1:0] + `AGC_EB_HI_OFFSET;
    end else begin
      exp_ram = a[`AGC_RAM_ADDR_W-1:0] + eb_lo * `AGC_RAM_BANK_SIZE;
    end
  endfunction

  // Idle bus and no response right out of reset
  a_reset_idle: assert property (@(posedge clk)
    $rose(rst_l) |-> !wb_ack && !xlate_rsp.valid)
    else begin fail_cnt++; $error("ack or response valid high after reset"); end

  // Strobe seen with ack low gets an ack on the next clock
  a_ack_follows_stb: assert property (@(posedge clk) disable iff (!rst_l)
    (wb_cyc && wb_stb && !wb_ack) |=> wb_ack)
    else begin fail_cnt++; $error("no ack one cycle after strobe"); end

  a_ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_l)
    wb_ack |=> !wb_ack)
    else begin fail_cnt++; $error("ack held longer than one cycle"); end

  a_ack_has_req: assert property (@(posedge clk) disable iff (!rst_l)
    wb_ack |-> $past(wb_cyc && wb_stb && !wb_ack))
    else begin fail_cnt++; $error("ack without a pending request"); end

  // Response valid exactly one cycle behind the request
  a_rsp_latency: assert property (@(posedge clk) disable iff (!rst_l)
    xlate_rsp.valid == $past(xlate_req.valid))
    else begin fail_cnt++; $error("response valid not one cycle after request"); end

  a_region_tag: assert property (@(posedge clk) disable iff (!rst_l)
    xlate_rsp.valid |-> xlate_rsp.region ==
      (($past(xlate_req.addr) >= `AGC_ROM_REGION) ? REGION_ROM : REGION_RAM))
    else begin fail_cnt++; $error("region tag does not follow octal 2000 boundary"); end

  a_rom_map: assert property (@(posedge clk) disable iff (!rst_l)
    (xlate_rsp.valid && $past(xlate_req.addr) >= `AGC_ROM_REGION) |->
      xlate_rsp.rom_addr == exp_rom($past(xlate_req.addr), $past(banks.fb)))
    else begin fail_cnt++; $error("ROM address mismatch"); end

  a_ram_map: assert property (@(posedge clk) disable iff (!rst_l)
    (xlate_rsp.valid && $past(xlate_req.addr) < `AGC_ROM_REGION) |->
      xlate_rsp.ram_addr == exp_ram($past(xlate_req.addr), $past(banks.eb)))
    else begin fail_cnt++; $error("RAM address mismatch"); end

  // Unused side parked at its lowest valid address
  a_inactive_side: assert property (@(posedge clk) disable iff (!rst_l)
    xlate_rsp.valid |-> (($past(xlate_req.addr) >= `AGC_ROM_REGION)
      ? (xlate_rsp.ram_addr == '0)
      : (xlate_rsp.rom_addr == `AGC_ROM_BANK_SIZE)))
    else begin fail_cnt++; $error("inactive side not at its lowest address"); end

endmodule

bind agc_addr_unit agc_addr_unit_assert u_assert (
  .clk       (clk),
  .rst_l     (rst_l),
  .wb_cyc    (wb_cyc),
  .wb_stb    (wb_stb),
  .wb_ack    (wb_ack),
  .xlate_req (xlate_req),
  .xlate_rsp (xlate_rsp),
  .banks     (banks)
);

//--- tb_agc_addr_unit.sv
// AGC address unit testbench
// Drives the bank register over Wishbone and streams translation
// requests under every FB and EB value. Readback is checked here,
// handshake and mapping by the bound checker.
`timescale 1ns/100ps
`include "agc_config.svh"

module tb_agc_addr_unit import agc_pkg::*;;

  // Roughly 8 banks x 60 cycles plus bus traffic, with wide margin
  localparam int CYCLE_LIMIT = 2000;
  localparam int REQS_PER_BANK = 50;

  logic                   clk;
  logic                   rst_l;
  logic                   wb_cyc;
  logic                   wb_stb;
  logic                   wb_we;
  bank_sel_e              wb_adr;
  logic [`AGC_WORD_W-1:0] wb_dat_w;
  logic [`AGC_WORD_W-1:0] wb_dat_r;
  logic                   wb_ack;
  xlate_req_t             xlate_req;
  xlate_rsp_t             xlate_rsp;

  // Bank contents as the bus writes should have left them
  logic [`AGC_BANK_W-1:0] eb_m;
  logic [`AGC_BANK_W-1:0] fb_m;
  int                     read_errs = 0;
  int                     cycle_cnt = 0;
  int unsigned            assert_errs;

  agc_addr_unit u_dut (
    .clk       (clk),
    .rst_l     (rst_l),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_w  (wb_dat_w),
    .wb_dat_r  (wb_dat_r),
    .wb_ack    (wb_ack),
    .xlate_req (xlate_req),
    .xlate_rsp (xlate_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Watchdog
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout: run still going after %0d clock cycles", CYCLE_LIMIT);
      $display(">>> FAIL");
      $finish;
    end
  end

  task automatic bus_write(input bank_sel_e sel, input logic [`AGC_WORD_W-1:0] data);
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= 1'b1;
    wb_adr   <= sel;
    wb_dat_w <= data;
    @(posedge clk);
    while (wb_ack !== 1'b1) @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
    // Field placement: EB 11:9, FB 14:12
    case (sel)
      EB_SEL: eb_m = data[11:9];
      FB_SEL: fb_m = data[14:12];
      BB_SEL: {fb_m, eb_m} = data[14:9];
      default: ;
    endcase
  endtask

  task automatic bus_read(input bank_sel_e sel, output logic [`AGC_WORD_W-1:0] data);
    @(posedge clk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we  <= 1'b0;
    wb_adr <= sel;
    @(posedge clk);
    while (wb_ack !== 1'b1) @(posedge clk);
    data = wb_dat_r;
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
  endtask

  task automatic check_read(input bank_sel_e sel);
    logic [`AGC_WORD_W-1:0] got;
    logic [`AGC_WORD_W-1:0] exp;
    exp = '0;
    case (sel)
      EB_SEL: exp[11:9] = eb_m;
      FB_SEL: exp[14:12] = fb_m;
      BB_SEL: exp[14:9] = {fb_m, eb_m};
      default: ;
    endcase
    bus_read(sel, got);
    if (got !== exp) begin
      read_errs++;
      $display("FAILED at %0t: read %s got %h expected %h", $time, sel.name(), got, exp);
    end
  endtask

  // Region edges, always sent first under each bank setting
  function automatic logic [`AGC_SOFT_ADDR_W-1:0] edge_addr(input int idx);
    case (idx)
      0: edge_addr = 12'o3777;
      1: edge_addr = 12'o4000;
      2: edge_addr = 12'o1377;
      3: edge_addr = 12'o1400;
      4: edge_addr = 12'o2000;
      5: edge_addr = 12'o1777;
      6: edge_addr = 12'o0000;
      default: edge_addr = 12'o7777;
    endcase
  endfunction

  // Back-to-back requests, one per cycle
  task automatic send_requests(input int n);
    logic [`AGC_SOFT_ADDR_W-1:0] a;
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      if (i < 8) a = edge_addr(i);
      else a = $urandom_range(4095, 0);
      xlate_req <= '{valid: 1'b1, addr: a};
    end
    @(posedge clk);
    xlate_req.valid <= 1'b0;
  endtask

  initial begin
    void'($urandom(24));
    rst_l     = 1'b0;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = EB_SEL;
    wb_dat_w  = '0;
    xlate_req = '0;
    eb_m      = '0;
    fb_m      = '0;
    repeat (4) @(posedge clk);
    rst_l <= 1'b1;

    // Banks clear after reset
    check_read(EB_SEL);
    check_read(FB_SEL);
    check_read(BB_SEL);

    // Single-field writes leave the other field alone
    bus_write(EB_SEL, 15'h7fff);
    check_read(EB_SEL);
    check_read(FB_SEL);
    bus_write(FB_SEL, 15'h5155);
    check_read(FB_SEL);
    check_read(EB_SEL);

    // Sweep FB up and EB down, translations under each pair
    for (int v = 0; v < 8; v++) begin
      bus_write(BB_SEL, {3'(v), 3'(7 - v), 9'($urandom)});
      check_read(BB_SEL);
      send_requests(REQS_PER_BANK);
    end
    check_read(EB_SEL);
    check_read(FB_SEL);

    // Let the last response reach the checker
    repeat (3) @(posedge clk);
    assert_errs = u_dut.u_assert.fail_cnt;
    $display("Errors: %0d readback, %0d assertion", read_errs, assert_errs);
    if (read_errs == 0 && assert_errs == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- compile.f
+incdir+.
agc_pkg.sv
bank_regs.sv
rom_translate.sv
ram_translate.sv
xlate_combine.sv
agc_addr_unit.sv
agc_addr_unit_assert.sv
tb_agc_addr_unit.sv

//--- Bender.yml
package:
  name: agc_addr_unit

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - agc_pkg.sv
      - bank_regs.sv
      - rom_translate.sv
      - ram_translate.sv
      - xlate_combine.sv
      - agc_addr_unit.sv
  - target: test
    include_dirs:
      - .
    files:
      - agc_addr_unit_assert.sv
      - tb_agc_addr_unit.sv
